//--- flist.f
+incdir+src
src/core_pkg.sv
src/core_ifs.sv
src/pipe_stage.sv
src/fetch_stage.sv
src/decode_stage.sv
src/bypass_unit.sv
src/execute_stage.sv
src/regfile.sv
src/core_top.sv
verification/tb_clock_gen.sv
verification/tb_core.sv

//--- Makefile
# Verilator build and run for the integer core testbench
# every variable below can be overridden, e.g. make test LOG=run.log

VERILATOR ?= verilator
TOP ?= tb_core
FLIST ?= flist.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verification/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module tb_core;

    localparam int NUM_INSTS = 400;
    // generous per-instruction budget plus reset and readback
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 8 + 200;

    // one expected retirement
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] inst;
        logic wen;
        logic [`REG_INDEX_WIDTH-1:0] windex;
        logic [`DATA_WIDTH-1:0] wdata;
        // unknown words leave wdata unspecified
        logic known;
    } expect_t;

    logic clk;
    logic reset;
    logic inst_valid;
    logic [`DATA_WIDTH-1:0] inst;
    logic inst_ready;
    logic commit_valid;
    logic commit_ready;
    logic [`DATA_WIDTH-1:0] commit_pc;
    logic [`DATA_WIDTH-1:0] commit_inst;
    logic commit_wen;
    logic [`REG_INDEX_WIDTH-1:0] commit_windex;
    logic [`DATA_WIDTH-1:0] commit_wdata;
    logic [`REG_INDEX_WIDTH-1:0] reg_num;
    logic [`DATA_WIDTH-1:0] rf_rdata;

    // reference model state
    logic [`DATA_WIDTH-1:0] model_regs [`REG_COUNT];
    logic [`DATA_WIDTH-1:0] model_pc;
    expect_t exp_q[$];
    logic [31:0] rand_state;
    int accepted;
    int presented;
    int committed;
    int cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(20.0)) i_clock_gen (.clk(clk));

    core_top i_core_top (
        .clk(clk),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_ready(inst_ready),
        .commit_valid(commit_valid),
        .commit_ready(commit_ready),
        .commit_pc(commit_pc),
        .commit_inst(commit_inst),
        .commit_wen(commit_wen),
        .commit_windex(commit_windex),
        .commit_wdata(commit_wdata),
        .reg_num(reg_num),
        .rf_rdata(rf_rdata)
    );

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected === actual) else begin
            stop_with_failure($sformatf("mismatch %s expected %h actual %h",
                                        name, expected, actual));
        end
    endtask

    // xorshift32
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rand_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rand_state = x;
        return x;
    endfunction

    // registers limited to r0..r7 so hazards come often
    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [31:0] word;
        logic [4:0] rd;
        logic [4:0] rj;
        logic [4:0] rk;
        r = next_rand();
        rd = {2'b00, r[2:0]};
        rj = {2'b00, r[5:3]};
        rk = {2'b00, r[8:6]};
        case (r[31:29])
            3'd0: word = {`OP_ADD_W, rk, rj, rd};
            3'd1: word = {`OP_SUB_W, rk, rj, rd};
            3'd2: word = {`OP_AND, rk, rj, rd};
            3'd3: word = {`OP_OR, rk, rj, rd};
            3'd4: word = {`OP_XOR, rk, rj, rd};
            3'd5: word = {`OP_ADDI_W, r[20:9], rj, rd};
            3'd6: word = {`OP_LU12I_W, r[28:9], rd};
            // top bits all ones, matches no opcode
            default: word = {6'h3f, r[28:3]};
        endcase
        return word;
    endfunction

    // architectural result from the model registers
    function automatic expect_t predict(input logic [31:0] pc, input logic [31:0] word);
        expect_t e;
        logic [31:0] a;
        logic [31:0] b;
        a = model_regs[word[9:5]];
        b = model_regs[word[14:10]];
        e.pc = pc;
        e.inst = word;
        e.windex = word[4:0];
        e.wdata = '0;
        e.known = 1'b1;
        if (word[31:15] == `OP_ADD_W) begin
            e.wdata = a + b;
        end else if (word[31:15] == `OP_SUB_W) begin
            e.wdata = a - b;
        end else if (word[31:15] == `OP_AND) begin
            e.wdata = a & b;
        end else if (word[31:15] == `OP_OR) begin
            e.wdata = a | b;
        end else if (word[31:15] == `OP_XOR) begin
            e.wdata = a ^ b;
        end else if (word[31:22] == `OP_ADDI_W) begin
            e.wdata = a + {{20{word[21]}}, word[21:10]};
        end else if (word[31:25] == `OP_LU12I_W) begin
            e.wdata = {word[24:5], 12'h000};
        end else begin
            e.known = 1'b0;
        end
        e.wen = e.known && (word[4:0] != 5'd0);
        return e;
    endfunction

    task automatic accept_inst();
        expect_t e;
        e = predict(model_pc, inst);
        exp_q.push_back(e);
        if (e.wen) begin
            model_regs[e.windex] = e.wdata;
        end
        model_pc = model_pc + 32'd4;
        accepted++;
    endtask

    task automatic check_commit();
        expect_t e;
        assert (exp_q.size() > 0) else begin
            stop_with_failure("commit seen with no instruction outstanding");
        end
        e = exp_q.pop_front();
        check_value($sformatf("commit_pc #%0d", committed), e.pc, commit_pc);
        check_value($sformatf("commit_inst #%0d", committed), e.inst, commit_inst);
        check_value($sformatf("commit_wen #%0d", committed), {31'b0, e.wen}, {31'b0, commit_wen});
        check_value($sformatf("commit_windex #%0d", committed),
                    {27'b0, e.windex}, {27'b0, commit_windex});
        if (e.known) begin
            check_value($sformatf("commit_wdata #%0d", committed), e.wdata, commit_wdata);
        end
        committed++;
    endtask

    // gaps on inst_valid, random back-pressure on commit
    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        if (!inst_valid || inst_ready) begin
            if (presented < NUM_INSTS && r[1:0] != 2'b00) begin
                inst_valid <= 1'b1;
                inst <= make_inst();
                presented++;
            end else begin
                inst_valid <= 1'b0;
            end
        end
        commit_ready <= r[4:2] > 3'd2;
        reg_num <= {2'b00, r[7:5]};
    endtask

    // a stalled commit holds every field
    assert property (@(posedge clk) disable iff (reset)
        (commit_valid && !commit_ready) |=> (commit_valid && $stable(commit_pc)
            && $stable(commit_inst) && $stable(commit_wen)
            && $stable(commit_windex) && $stable(commit_wdata)))
    else stop_with_failure("commit outputs changed while commit_ready was low");

    // r0 always reads zero on the debug port
    assert property (@(posedge clk) disable iff (reset) (reg_num == 5'd0) |-> (rf_rdata == '0))
    else stop_with_failure($sformatf("mismatch debug read r0 expected %h actual %h",
                                     32'h0, $sampled(rf_rdata)));

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure($sformatf("timeout, run did not finish in %0d cycles",
                                        TIMEOUT_CYCLES));
        end
    end

    initial begin
        reset <= 1'b1;
        inst_valid <= 1'b0;
        inst <= '0;
        commit_ready <= 1'b0;
        reg_num <= '0;
        rand_state = 32'd23;
        model_pc = `RESET_PC;
        accepted = 0;
        presented = 0;
        committed = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        assert (!commit_valid && inst_ready) else begin
            stop_with_failure("after reset commit_valid is not low or inst_ready is not high");
        end
        // handshakes of each edge first, then the next drive
        while (accepted < NUM_INSTS || exp_q.size() > 0) begin
            if (commit_valid && commit_ready) begin
                check_commit();
            end
            if (inst_valid && inst_ready) begin
                accept_inst();
            end
            drive_inputs();
            @(posedge clk);
        end
        inst_valid <= 1'b0;
        commit_ready <= 1'b1;
        // drained, read back every register
        for (int i = 0; i < `REG_COUNT; i++) begin
            reg_num <= i[4:0];
            @(posedge clk);
            assert (!commit_valid) else begin
                stop_with_failure("extra commit after all instructions retired");
            end
            check_value($sformatf("final r%0d", i), model_regs[i], rf_rdata);
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

// free-running testbench clock
module tb_clock_gen #(
    parameter real PERIOD_NS = 20.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        // half period high, half period low
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

endmodule

`default_nettype wire

//--- src/core_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module core_top (
    input logic clk,
    input logic reset,
    // instruction stream in
    input logic inst_valid,
    input logic [`DATA_WIDTH-1:0] inst,
    output logic inst_ready,
    // retired instructions out
    output logic commit_valid,
    input logic commit_ready,
    output logic [`DATA_WIDTH-1:0] commit_pc,
    output logic [`DATA_WIDTH-1:0] commit_inst,
    output logic commit_wen,
    output logic [`REG_INDEX_WIDTH-1:0] commit_windex,
    output logic [`DATA_WIDTH-1:0] commit_wdata,
    // debug register read
    input logic [`REG_INDEX_WIDTH-1:0] reg_num,
    output logic [`DATA_WIDTH-1:0] rf_rdata
);

    logic id_valid;
    logic id_ready;
    core_pkg::id_payload_t id_item;
    logic ex_valid;
    logic ex_ready;
    core_pkg::ex_payload_t ex_item;
    logic wb_valid;
    core_pkg::wb_payload_t wb_item;
    logic commit_fire;

    reg_read_if decode_read ();
    reg_read_if rf_read ();
    bypass_if ex_bypass ();
    bypass_if wb_bypass ();

    fetch_stage i_fetch_stage (
        .clk(clk),
        .reset(reset),
        .inst_valid(inst_valid),
        .inst(inst),
        .inst_ready(inst_ready),
        .out_valid(id_valid),
        .out_ready(id_ready),
        .out_data(id_item)
    );

    decode_stage i_decode_stage (
        .clk(clk),
        .reset(reset),
        .in_valid(id_valid),
        .in_ready(id_ready),
        .in_data(id_item),
        .rf(decode_read.requester),
        .out_valid(ex_valid),
        .out_ready(ex_ready),
        .out_data(ex_item)
    );

    bypass_unit i_bypass_unit (
        .decode_port(decode_read.provider),
        .rf_port(rf_read.requester),
        .ex_src(ex_bypass.sink),
        .wb_src(wb_bypass.sink)
    );

    // writeback register drains straight into the commit port
    execute_stage i_execute_stage (
        .clk(clk),
        .reset(reset),
        .in_valid(ex_valid),
        .in_ready(ex_ready),
        .in_data(ex_item),
        .ex_bypass(ex_bypass.source),
        .out_valid(wb_valid),
        .out_ready(commit_ready),
        .out_data(wb_item)
    );

    // register written only when the commit is taken
    assign commit_fire = commit_valid && commit_ready;

    regfile i_regfile (
        .clk(clk),
        .reset(reset),
        .rd(rf_read.provider),
        .debug_index(reg_num),
        .debug_data(rf_rdata),
        .wen(commit_fire && wb_item.wen),
        .windex(wb_item.windex),
        .wdata(wb_item.result)
    );

    // writeback item stays visible to decode until it commits
    assign wb_bypass.valid = wb_valid;
    assign wb_bypass.wen = wb_item.wen;
    assign wb_bypass.index = wb_item.windex;
    assign wb_bypass.value = wb_item.result;

    assign commit_valid = wb_valid;
    assign commit_pc = wb_item.pc;
    assign commit_inst = wb_item.inst;
    assign commit_wen = wb_item.wen;
    assign commit_windex = wb_item.windex;
    assign commit_wdata = wb_item.result;

endmodule

`default_nettype wire

//--- src/regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module regfile (
    input logic clk,
    input logic reset,
    reg_read_if.provider rd,
    input logic [`REG_INDEX_WIDTH-1:0] debug_index,
    output logic [`DATA_WIDTH-1:0] debug_data,
    input logic wen,
    input logic [`REG_INDEX_WIDTH-1:0] windex,
    input logic [`DATA_WIDTH-1:0] wdata
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // r0 is hardwired to zero
    function automatic logic [`DATA_WIDTH-1:0] read_reg(
        input logic [`REG_INDEX_WIDTH-1:0] index
    );
        if (index == '0) begin
            return '0;
        end
        return regs[index];
    endfunction

    // combinational reads, no write-through
    assign rd.data1 = read_reg(rd.index1);
    assign rd.data2 = read_reg(rd.index2);
    assign debug_data = read_reg(debug_index);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (windex != '0)) begin
            regs[windex] <= wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module execute_stage (
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input core_pkg::ex_payload_t in_data,
    bypass_if.source ex_bypass,
    output logic out_valid,
    input logic out_ready,
    output core_pkg::wb_payload_t out_data
);

    logic [`DATA_WIDTH-1:0] alu_result;
    core_pkg::wb_payload_t wb_item;

    // add and sub wrap, no overflow trap
    always_comb begin
        case (in_data.alu_op)
            core_pkg::ALU_ADD: alu_result = in_data.src1 + in_data.src2;
            core_pkg::ALU_SUB: alu_result = in_data.src1 - in_data.src2;
            core_pkg::ALU_AND: alu_result = in_data.src1 & in_data.src2;
            core_pkg::ALU_OR: alu_result = in_data.src1 | in_data.src2;
            core_pkg::ALU_XOR: alu_result = in_data.src1 ^ in_data.src2;
            core_pkg::ALU_PASS: alu_result = in_data.src2;
            default: alu_result = '0;
        endcase
    end

    // held item offered for forwarding, also while stalled
    assign ex_bypass.valid = in_valid;
    assign ex_bypass.wen = in_data.wen;
    assign ex_bypass.index = in_data.windex;
    assign ex_bypass.value = alu_result;

    always_comb begin
        wb_item.pc = in_data.pc;
        wb_item.inst = in_data.inst;
        wb_item.wen = in_data.wen;
        wb_item.windex = in_data.windex;
        wb_item.result = alu_result;
    end

    // writeback register
    pipe_stage #(.payload_t(core_pkg::wb_payload_t)) i_wb_reg (
        .clk(clk),
        .reset(reset),
        .left_valid(in_valid),
        .left_ready(in_ready),
        .left_data(wb_item),
        .right_valid(out_valid),
        .right_ready(out_ready),
        .right_data(out_data)
    );

endmodule

`default_nettype wire

//--- src/bypass_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_unit (
    reg_read_if.provider decode_port,
    reg_read_if.requester rf_port,
    bypass_if.sink ex_src,
    bypass_if.sink wb_src
);

    logic ex_hit1;
    logic ex_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // indices go straight on to the register file
    assign rf_port.index1 = decode_port.index1;
    assign rf_port.index2 = decode_port.index2;

    // wen is already low for r0, so no index-zero check here
    assign ex_hit1 = ex_src.valid && ex_src.wen && (ex_src.index == decode_port.index1);
    assign ex_hit2 = ex_src.valid && ex_src.wen && (ex_src.index == decode_port.index2);
    assign wb_hit1 = wb_src.valid && wb_src.wen && (wb_src.index == decode_port.index1);
    assign wb_hit2 = wb_src.valid && wb_src.wen && (wb_src.index == decode_port.index2);

    // youngest producer wins
    always_comb begin
        if (ex_hit1) begin
            decode_port.data1 = ex_src.value;
        end else if (wb_hit1) begin
            decode_port.data1 = wb_src.value;
        end else begin
            decode_port.data1 = rf_port.data1;
        end
        if (ex_hit2) begin
            decode_port.data2 = ex_src.value;
        end else if (wb_hit2) begin
            decode_port.data2 = wb_src.value;
        end else begin
            decode_port.data2 = rf_port.data2;
        end
    end

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module decode_stage (
    input logic clk,
    input logic reset,
    input logic in_valid,
    output logic in_ready,
    input core_pkg::id_payload_t in_data,
    reg_read_if.requester rf,
    output logic out_valid,
    input logic out_ready,
    output core_pkg::ex_payload_t out_data
);

    logic [`DATA_WIDTH-1:0] inst;
    logic [`REG_INDEX_WIDTH-1:0] rd;
    logic [`REG_INDEX_WIDTH-1:0] rj;
    logic [`REG_INDEX_WIDTH-1:0] rk;
    logic is_reg_op;
    logic is_addi;
    logic is_lu12i;
    logic known;
    core_pkg::alu_op_e reg_alu_op;
    core_pkg::ex_payload_t ex_item;

    assign inst = in_data.inst;

    // register fields, fixed positions in every format
    assign rd = inst[4:0];
    assign rj = inst[9:5];
    assign rk = inst[14:10];

    // operands always requested, unused ones are ignored
    assign rf.index1 = rj;
    assign rf.index2 = rk;

    // 3r forms share the 17-bit opcode field
    always_comb begin
        is_reg_op = 1'b1;
        reg_alu_op = core_pkg::ALU_ADD;
        case (inst[31:15])
            `OP_ADD_W: reg_alu_op = core_pkg::ALU_ADD;
            `OP_SUB_W: reg_alu_op = core_pkg::ALU_SUB;
            `OP_AND: reg_alu_op = core_pkg::ALU_AND;
            `OP_OR: reg_alu_op = core_pkg::ALU_OR;
            `OP_XOR: reg_alu_op = core_pkg::ALU_XOR;
            default: is_reg_op = 1'b0;
        endcase
    end

    assign is_addi = inst[31:22] == `OP_ADDI_W;
    assign is_lu12i = inst[31:25] == `OP_LU12I_W;
    assign known = is_reg_op || is_addi || is_lu12i;

    always_comb begin
        ex_item.pc = in_data.pc;
        ex_item.inst = inst;
        ex_item.src1 = rf.data1;
        ex_item.windex = rd;
        // r0 is never written
        ex_item.wen = known && (rd != '0);
        if (is_reg_op) begin
            ex_item.alu_op = reg_alu_op;
            ex_item.src2 = rf.data2;
        end else if (is_addi) begin
            // si12 sign-extended
            ex_item.alu_op = core_pkg::ALU_ADD;
            ex_item.src2 = {{20{inst[21]}}, inst[21:10]};
        end else if (is_lu12i) begin
            // si20 into the upper bits
            ex_item.alu_op = core_pkg::ALU_PASS;
            ex_item.src2 = {inst[24:5], 12'b0};
        end else begin
            // unknown word, retires with a zero result
            ex_item.alu_op = core_pkg::ALU_PASS;
            ex_item.src2 = '0;
        end
    end

    // execute-stage register
    pipe_stage #(.payload_t(core_pkg::ex_payload_t)) i_ex_reg (
        .clk(clk),
        .reset(reset),
        .left_valid(in_valid),
        .left_ready(in_ready),
        .left_data(ex_item),
        .right_valid(out_valid),
        .right_ready(out_ready),
        .right_data(out_data)
    );

endmodule

`default_nettype wire

//--- src/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

module fetch_stage (
    input logic clk,
    input logic reset,
    input logic inst_valid,
    input logic [`DATA_WIDTH-1:0] inst,
    output logic inst_ready,
    output logic out_valid,
    input logic out_ready,
    output core_pkg::id_payload_t out_data
);

    logic [`DATA_WIDTH-1:0] pc;
    core_pkg::id_payload_t fetch_item;

    // pair the incoming word with the current pc
    always_comb begin
        fetch_item.pc = pc;
        fetch_item.inst = inst;
    end

    // next pc only once the word is taken
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (inst_valid && inst_ready) begin
            pc <= pc + `DATA_WIDTH'd4;
        end
    end

    // decode-stage register
    pipe_stage #(.payload_t(core_pkg::id_payload_t)) i_id_reg (
        .clk(clk),
        .reset(reset),
        .left_valid(inst_valid),
        .left_ready(inst_ready),
        .left_data(fetch_item),
        .right_valid(out_valid),
        .right_ready(out_ready),
        .right_data(out_data)
    );

endmodule

`default_nettype wire

//--- src/pipe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_stage #(
    parameter type payload_t = logic
) (
    input logic clk,
    input logic reset,
    input logic left_valid,
    output logic left_ready,
    input payload_t left_data,
    output logic right_valid,
    input logic right_ready,
    output payload_t right_data
);

    logic full;
    payload_t item;

    // take a new item when empty or when the held one leaves now
    assign left_ready = !full || right_ready;
    assign right_valid = full;
    assign right_data = item;

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (left_valid && left_ready) begin
            full <= 1'b1;
        end else if (right_ready) begin
            // drained with nothing behind it
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (left_valid && left_ready) begin
            item <= left_data;
        end
    end

endmodule

`default_nettype wire

//--- src/core_ifs.sv
`timescale 1ns/1ps
`default_nettype none

`include "core_defines.svh"

// two combinational register reads
interface reg_read_if;
    logic [`REG_INDEX_WIDTH-1:0] index1;
    logic [`REG_INDEX_WIDTH-1:0] index2;
    logic [`DATA_WIDTH-1:0] data1;
    logic [`DATA_WIDTH-1:0] data2;

    // requester drives indices, provider answers with data
    modport requester (output index1, output index2, input data1, input data2);
    modport provider (input index1, input index2, output data1, output data2);
endinterface

// one in-flight result offered for forwarding
interface bypass_if;
    logic valid;
    logic wen;
    logic [`REG_INDEX_WIDTH-1:0] index;
    logic [`DATA_WIDTH-1:0] value;

    modport source (output valid, output wen, output index, output value);
    modport sink (input valid, input wen, input index, input value);
endinterface

`default_nettype wire

//--- src/core_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_pkg;

    // alu function selected in decode
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        // result is the second operand as is
        ALU_PASS
    } alu_op_e;

    // fetch to decode
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] inst;
    } id_payload_t;

    // decode to execute, operands already resolved
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] inst;
        alu_op_e alu_op;
        logic [`DATA_WIDTH-1:0] src1;
        logic [`DATA_WIDTH-1:0] src2;
        // low for r0 destinations and unknown words
        logic wen;
        logic [`REG_INDEX_WIDTH-1:0] windex;
    } ex_payload_t;

    // execute to writeback / commit
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] pc;
        logic [`DATA_WIDTH-1:0] inst;
        logic wen;
        logic [`REG_INDEX_WIDTH-1:0] windex;
        logic [`DATA_WIDTH-1:0] result;
    } wb_payload_t;

endpackage

`default_nettype wire

//--- src/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and pc width
`define DATA_WIDTH 32

// register file geometry
`define REG_INDEX_WIDTH 5
`define REG_COUNT 32

// pc given to the first accepted instruction
`define RESET_PC 32'h1c00_0000

// 3r-type opcodes, compared against inst[31:15]
`define OP_ADD_W 17'h00020
`define OP_SUB_W 17'h00022
`define OP_AND 17'h00029
`define OP_OR 17'h0002a
`define OP_XOR 17'h0002b

// 2ri12-type opcode, inst[31:22]
`define OP_ADDI_W 10'h00a

// 1ri20-type opcode, inst[31:25]
`define OP_LU12I_W 7'h0a

`endif
